// File: bench/calib_checker.sv
// Calibration checker that models the coefficient bank, predicts each output beat and compares
`timescale 1ns/1ps
`include "calib_settings.svh"

module calib_checker
    import calib_pkg::*;
(
    input logic clock,
    input logic reset,
    input stream_beat_t in_beat,
    input logic in_valid,
    input logic in_ready,
    input stream_beat_t out_beat,
    input logic out_valid,
    input logic out_ready,
    input logic shift_enable,
    input logic coeff_write,
    input channel_t coeff_channel,
    input coeff_field_t coeff_field,
    input sample_t coeff_data,
    output int error_count,
    output int accepted_count,
    output int beat_count
);

    // Offset zero, no shift and signed limits leave a sample as it is
    localparam channel_coeff_t NEUTRAL = '{offset: '0, shift: '0, output_signed: 1'b1};

    // Reference copy of the bank and the beats the DUT owes, oldest first
    channel_coeff_t model [`CALIB_N_CHANNELS];
    stream_beat_t expected [$];

    // Applies offset, clip and optional shift to one accepted beat
    function automatic stream_beat_t predict(input stream_beat_t beat, input logic shift_on);
        stream_beat_t result;
        channel_coeff_t coeff;
        int channel;
        int sum;
        int upper;
        int lower;
        result = beat;
        channel = int'(beat.dest) - `CALIB_BASE_ADDR;
        coeff = NEUTRAL;
        if (channel >= 0 && channel < `CALIB_N_CHANNELS) begin
            coeff = model[channel_t'(channel)];
        end
        upper = (1 << (`CALIB_DATA_WIDTH - 1)) - 1;
        lower = coeff.output_signed ? -(1 << (`CALIB_DATA_WIDTH - 1)) : 0;
        sum = int'($signed(beat.data)) + int'($signed(coeff.offset));
        if (sum > upper) begin
            sum = upper;
        end else if (sum < lower) begin
            sum = lower;
        end
        // Bits pushed past the sample width are dropped
        if (shift_on) begin
            sum = sum << coeff.shift;
        end
        result.data = sample_t'(sum);
        return result;
    endfunction

    task automatic check_field(input string name, input logic [31:0] want, input logic [31:0] got);
        if (want !== got) begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, want, got);
            error_count++;
        end
    endtask

    initial begin
        error_count = 0;
        accepted_count = 0;
        beat_count = 0;
    end

    // Inputs settle at the falling edge, so the rising edge sees them stable
    always @(posedge clock) begin
        // Back-pressure reaches the input side in the same cycle
        check_field("in_ready", 32'(out_ready), 32'(in_ready));
        if (!reset) begin
            for (int i = 0; i < `CALIB_N_CHANNELS; i++) begin
                model[channel_t'(i)] = NEUTRAL;
            end
        end else begin
            // A beat taken at this edge still sees the coefficients from before a write here
            if (in_valid && out_ready) begin
                expected.push_back(predict(in_beat, shift_enable));
                accepted_count++;
            end
            if (coeff_write) begin
                case (coeff_field)
                    FIELD_OFFSET: model[coeff_channel].offset = coeff_data;
                    FIELD_SHIFT: model[coeff_channel].shift = shift_t'(coeff_data);
                    FIELD_SIGNED: model[coeff_channel].output_signed = coeff_data[0];
                    default: begin
                    end
                endcase
            end
        end
    end

    // Outputs change at the rising edge and are compared half a period later
    always @(negedge clock) begin
        if (out_valid === 1'b1) begin
            if (beat_count >= expected.size()) begin
                $display("ERROR time %0t: out_valid high with no beat accepted", $time);
                error_count++;
            end else begin
                check_field("out_beat.data", 32'($unsigned(expected[beat_count].data)),
                    32'($unsigned(out_beat.data)));
                check_field("out_beat.dest", 32'(expected[beat_count].dest), 32'(out_beat.dest));
                check_field("out_beat.user", 32'(expected[beat_count].user), 32'(out_beat.user));
                beat_count++;
            end
        end else if (beat_count < expected.size()) begin
            // Latency is one cycle, so an owed beat that is not here now is lost
            $display("ERROR time %0t: accepted beat %0d never came out", $time, beat_count);
            error_count++;
            beat_count = expected.size();
        end
    end

endmodule

// File: bench/calib_tb.sv
// Calibration front end testbench driving LFSR beats, host writes and back-pressure
`timescale 1ns/1ps
`include "calib_settings.svh"

module calib_tb
    import calib_pkg::*;
();

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int BEATS_NEUTRAL = 20;
    localparam int BEATS_SIGNED = 200;
    localparam int BEATS_UNSIGNED = 150;
    localparam int BEATS_SHIFT = 150;
    localparam int BEATS_MIXED = 300;
    localparam int BEATS_UPDATE = 100;
    // Four clock periods for every beat of the whole run
    localparam int TIMEOUT_NS = (BEATS_NEUTRAL + BEATS_SIGNED + BEATS_UNSIGNED + BEATS_SHIFT
        + BEATS_MIXED + BEATS_UPDATE) * CLOCK_PERIOD * 4;
    localparam sample_t SAMPLE_MIN = {1'b1, {(`CALIB_DATA_WIDTH-1){1'b0}}};

    logic clock;
    logic reset;
    stream_beat_t in_beat;
    logic in_valid;
    logic in_ready;
    stream_beat_t out_beat;
    logic out_valid;
    logic out_ready;
    logic shift_enable;
    logic coeff_write;
    channel_t coeff_channel;
    coeff_field_t coeff_field;
    sample_t coeff_data;
    int error_count;
    int accepted_count;
    int beat_count;

    logic [31:0] lfsr_state = 32'hfabe;
    int sent_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int errors_before = 0;
    coeff_field_t field;

    calib_frontend dut (.*);
    calib_checker beat_checker (.*);

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic next_lfsr_bit();
        logic feedback;
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], next_lfsr_bit()};
        end
        return value;
    endfunction

    // Window-only beats address a channel, others may land anywhere in the address space
    function automatic stream_beat_t random_beat(input logic window_only);
        stream_beat_t beat;
        beat.data = sample_t'(random_bits(`CALIB_DATA_WIDTH));
        if (window_only || next_lfsr_bit()) begin
            beat.dest = dest_t'(`CALIB_BASE_ADDR)
                + dest_t'(random_bits($clog2(`CALIB_N_CHANNELS)));
        end else begin
            beat.dest = dest_t'(random_bits(`CALIB_DEST_WIDTH));
        end
        beat.user = user_t'(random_bits(`CALIB_USER_WIDTH));
        return beat;
    endfunction

    // Every task starts and ends right after a falling edge
    task automatic send_beat(input stream_beat_t beat, input logic stall);
        in_beat = beat;
        in_valid = 1'b1;
        out_ready = stall ? next_lfsr_bit() : 1'b1;
        @(negedge clock);
        while (!out_ready) begin
            out_ready = next_lfsr_bit();
            @(negedge clock);
        end
        sent_count++;
    endtask

    task automatic write_coeff(input channel_t channel, input coeff_field_t sel, input sample_t data);
        in_valid = 1'b0;
        coeff_write = 1'b1;
        coeff_channel = channel;
        coeff_field = sel;
        coeff_data = data;
        @(negedge clock);
        coeff_write = 1'b0;
    endtask

    // Idles the stream until the checker has seen every accepted beat
    task automatic finish_test(input int number, input string name);
        in_valid = 1'b0;
        out_ready = 1'b1;
        @(negedge clock);
        while (accepted_count != beat_count) begin
            @(negedge clock);
        end
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %0d %s: passed", number, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", number, name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run still busy after %0d ns", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        in_beat = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        shift_enable = 1'b0;
        coeff_write = 1'b0;
        coeff_channel = '0;
        coeff_field = FIELD_OFFSET;
        coeff_data = '0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);

        // All channels are neutral, so shift_enable makes no difference yet
        for (int i = 0; i < BEATS_NEUTRAL; i++) begin
            shift_enable = next_lfsr_bit();
            send_beat(random_beat(1'b0), 1'b0);
        end
        finish_test(1, "neutral after reset");

        // Full-range offsets push many sums past both signed limits
        shift_enable = 1'b0;
        for (int ch = 0; ch < `CALIB_N_CHANNELS; ch++) begin
            write_coeff(channel_t'(ch), FIELD_OFFSET, sample_t'(random_bits(`CALIB_DATA_WIDTH)));
        end
        for (int i = 0; i < BEATS_SIGNED; i++) begin
            send_beat(random_beat(1'b1), 1'b0);
        end
        finish_test(2, "signed offsets");

        // Even channels become unsigned and every offset is negative
        for (int ch = 0; ch < `CALIB_N_CHANNELS; ch++) begin
            write_coeff(channel_t'(ch), FIELD_SIGNED, sample_t'(ch % 2));
            write_coeff(channel_t'(ch), FIELD_OFFSET,
                sample_t'(random_bits(`CALIB_DATA_WIDTH)) | SAMPLE_MIN);
        end
        for (int i = 0; i < BEATS_UNSIGNED; i++) begin
            send_beat(random_beat(1'b1), 1'b0);
        end
        finish_test(3, "unsigned clip at zero");

        for (int ch = 0; ch < `CALIB_N_CHANNELS; ch++) begin
            write_coeff(channel_t'(ch), FIELD_SHIFT, sample_t'(random_bits(`CALIB_SHIFT_WIDTH)));
            write_coeff(channel_t'(ch), FIELD_SIGNED, sample_t'(random_bits(1)));
        end
        for (int i = 0; i < BEATS_SHIFT; i++) begin
            shift_enable = next_lfsr_bit();
            send_beat(random_beat(1'b1), 1'b0);
        end
        finish_test(4, "shift and truncate");

        // Addresses outside the window must come out untouched under back-pressure
        for (int i = 0; i < BEATS_MIXED; i++) begin
            shift_enable = next_lfsr_bit();
            send_beat(random_beat(1'b0), 1'b1);
        end
        finish_test(5, "address window and back-pressure");

        // A write alongside a beat lands after it, a write alone lands before the next
        for (int i = 0; i < BEATS_UPDATE; i++) begin
            field = coeff_field_t'(random_bits(2));
            if (field == 2'd3) begin
                field = FIELD_OFFSET;
            end
            case (random_bits(2))
                0: begin
                    coeff_write = 1'b1;
                    coeff_channel = channel_t'(random_bits($clog2(`CALIB_N_CHANNELS)));
                    coeff_field = field;
                    coeff_data = sample_t'(random_bits(`CALIB_DATA_WIDTH));
                    send_beat(random_beat(1'b1), 1'b0);
                    coeff_write = 1'b0;
                end
                1: begin
                    write_coeff(channel_t'(random_bits($clog2(`CALIB_N_CHANNELS))), field,
                        sample_t'(random_bits(`CALIB_DATA_WIDTH)));
                    send_beat(random_beat(1'b1), 1'b0);
                end
                default: send_beat(random_beat(1'b1), 1'b0);
            endcase
        end
        finish_test(6, "writes between beats");

        if (accepted_count != sent_count) begin
            $display("beat count mismatch: bench sent %0d, checker saw %0d", sent_count,
                accepted_count);
            tests_failed++;
        end
        $display("summary: tests passed %0d, tests failed %0d, beats checked %0d, errors %0d",
            tests_passed, tests_failed, beat_count, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/calib_pkg.sv
rtl/saturating_adder.sv
rtl/calib_coeff_bank.sv
rtl/calibration.sv
rtl/calib_frontend.sv
bench/calib_checker.sv
bench/calib_tb.sv

// File: rtl/calib_coeff_bank.sv
// Coefficient bank that holds per-channel offset, shift and signedness and looks them up by address
`timescale 1ns/1ps
`include "calib_settings.svh"

module calib_coeff_bank
    import calib_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic coeff_write,
    input channel_t coeff_channel,
    input coeff_field_t coeff_field,
    input sample_t coeff_data,
    input dest_t lookup_dest,
    output channel_coeff_t lookup_coeff
);

    // One coefficient set per channel of the window
    channel_coeff_t coeff_regs [`CALIB_N_CHANNELS];

    // Address relative to the window base, wraps for addresses below it
    dest_t rel_dest;
    logic in_window;

    always_ff @(posedge clock) begin
        if (!reset) begin
            // Every channel starts neutral, so beats pass unchanged
            for (int i = 0; i < `CALIB_N_CHANNELS; i++) begin
                coeff_regs[i] <= COEFF_NEUTRAL;
            end
        end else if (coeff_write) begin
            // Only the selected field of the selected channel changes
            case (coeff_field)
                FIELD_OFFSET: begin
                    coeff_regs[coeff_channel].offset <= coeff_data;
                end
                FIELD_SHIFT: begin
                    // The shift amount sits in the low bits of the write data
                    coeff_regs[coeff_channel].shift <= coeff_data[`CALIB_SHIFT_WIDTH-1:0];
                end
                FIELD_SIGNED: begin
                    coeff_regs[coeff_channel].output_signed <= coeff_data[0];
                end
                default: begin
                    // Code 3 selects nothing and the write is dropped
                end
            endcase
        end
    end

    // Addresses below the base wrap to large values and fall outside as well
    assign rel_dest = lookup_dest - dest_t'(`CALIB_BASE_ADDR);
    assign in_window = rel_dest < dest_t'(`CALIB_N_CHANNELS);

    // The lookup is combinational, so a write applies to the very next transfer
    always_comb begin
        if (in_window) begin
            lookup_coeff = coeff_regs[channel_t'(rel_dest)];
        end else begin
            lookup_coeff = COEFF_NEUTRAL;
        end
    end

    // The host must only strobe one of the three defined field codes
    a_field_legal: assert property (
        @(posedge clock) disable iff (!reset)
        coeff_write |-> (coeff_field != 2'd3)
    ) else $error("coefficient write with undefined field code");

endmodule

// File: rtl/calib_frontend.sv
// Calibration front end top level joining the coefficient bank and the calibration stream stage
`timescale 1ns/1ps

module calib_frontend
    import calib_pkg::*;
(
    input logic clock,
    input logic reset,
    input stream_beat_t in_beat,
    input logic in_valid,
    output logic in_ready,
    output stream_beat_t out_beat,
    output logic out_valid,
    input logic out_ready,
    input logic shift_enable,
    input logic coeff_write,
    input channel_t coeff_channel,
    input coeff_field_t coeff_field,
    input sample_t coeff_data
);

    // Address the stage looks up and the coefficients the bank returns
    dest_t lookup_dest;
    channel_coeff_t lookup_coeff;

    // Host writes land here and are read back by stream address
    calib_coeff_bank coeff_bank (
        .clock(clock),
        .reset(reset),
        .coeff_write(coeff_write),
        .coeff_channel(coeff_channel),
        .coeff_field(coeff_field),
        .coeff_data(coeff_data),
        .lookup_dest(lookup_dest),
        .lookup_coeff(lookup_coeff)
    );

    // Stream stage with one cycle of latency
    calibration calib_stage (
        .clock(clock),
        .reset(reset),
        .in_beat(in_beat),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_beat(out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .shift_enable(shift_enable),
        .lookup_dest(lookup_dest),
        .lookup_coeff(lookup_coeff)
    );

endmodule

// File: rtl/calib_pkg.sv
// Calibration package with the stream beat, coefficient and field selector types
`include "calib_settings.svh"

package calib_pkg;

    // Samples are two's complement throughout the data path
    typedef logic signed [`CALIB_DATA_WIDTH-1:0] sample_t;
    typedef logic [`CALIB_DEST_WIDTH-1:0] dest_t;
    typedef logic [`CALIB_USER_WIDTH-1:0] user_t;
    typedef logic [`CALIB_SHIFT_WIDTH-1:0] shift_t;

    // Index of a channel inside the window
    typedef logic [$clog2(`CALIB_N_CHANNELS)-1:0] channel_t;

    // One beat of the sample stream, data in the top bits
    typedef struct packed {
        sample_t data;
        dest_t dest;
        user_t user;
    } stream_beat_t;

    // Everything the stage needs to calibrate one channel
    typedef struct packed {
        sample_t offset;
        shift_t shift;
        logic output_signed;
    } channel_coeff_t;

    // Selects which coefficient a host write changes, 3 is not a legal code
    typedef logic [1:0] coeff_field_t;
    localparam coeff_field_t FIELD_OFFSET = 2'd0;
    localparam coeff_field_t FIELD_SHIFT = 2'd1;
    localparam coeff_field_t FIELD_SIGNED = 2'd2;

    // Coefficients that leave a sample unchanged
    localparam channel_coeff_t COEFF_NEUTRAL = '{offset: '0, shift: '0, output_signed: 1'b1};

endpackage

// File: rtl/calib_settings.svh
// Calibration stage settings with the stream widths, channel count and channel window base
`ifndef CALIB_SETTINGS_SVH
`define CALIB_SETTINGS_SVH

// Width of one raw or calibrated sample
`define CALIB_DATA_WIDTH 16

// Width of the stream destination address that names a channel
`define CALIB_DEST_WIDTH 8

// Width of the user tag carried untouched through the stage
`define CALIB_USER_WIDTH 8

// Width of the per-channel left shift amount
`define CALIB_SHIFT_WIDTH 4

// Number of channels owned by this block
`define CALIB_N_CHANNELS 4

// First stream address of the channel window
`define CALIB_BASE_ADDR 8

`endif

// File: rtl/calibration.sv
// Calibration stream stage that adds a saturating offset, applies an optional shift and registers the beat
`timescale 1ns/1ps
`include "calib_settings.svh"

module calibration
    import calib_pkg::*;
(
    input logic clock,
    input logic reset,
    input stream_beat_t in_beat,
    input logic in_valid,
    output logic in_ready,
    output stream_beat_t out_beat,
    output logic out_valid,
    input logic out_ready,
    input logic shift_enable,
    output dest_t lookup_dest,
    input channel_coeff_t lookup_coeff
);

    // Largest and smallest values a signed sample can hold
    localparam sample_t SAMPLE_MAX = {1'b0, {(`CALIB_DATA_WIDTH-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(`CALIB_DATA_WIDTH-1){1'b0}}};

    // A beat moves when the source offers it and the sink can take it
    logic transfer;

    // Lower clip bound for the addressed channel
    sample_t limit_neg;

    // Offset sum after clipping, then after the optional shift
    sample_t clipped_sum;
    sample_t shifted_sum;
    sample_t calibrated;

    // Back-pressure passes straight through, the stage holds no skid buffer
    assign in_ready = out_ready;
    assign transfer = in_valid & out_ready;

    // The bank is addressed by the beat currently on the input
    assign lookup_dest = in_beat.dest;

    // Unsigned channels bottom out at zero instead of the signed minimum
    assign limit_neg = lookup_coeff.output_signed ? SAMPLE_MIN : '0;

    saturating_adder #(
        .DATA_WIDTH(`CALIB_DATA_WIDTH)
    ) offset_adder (
        .a(in_beat.data),
        .b(lookup_coeff.offset),
        .limit_pos(SAMPLE_MAX),
        .limit_neg(limit_neg),
        .sum(clipped_sum)
    );

    // Bits shifted past the top are lost, the result keeps the sample width
    assign shifted_sum = clipped_sum << lookup_coeff.shift;

    // The shift applies to all channels at once, under control of one level
    assign calibrated = shift_enable ? shifted_sum : clipped_sum;

    // out_valid follows each edge, so it falls whenever no beat was taken
    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= transfer;
        end
    end

    // Payload only loads on a transfer and is qualified by out_valid
    always_ff @(posedge clock) begin
        if (transfer) begin
            out_beat.data <= calibrated;
            out_beat.dest <= in_beat.dest;
            out_beat.user <= in_beat.user;
        end
    end

    // No beat may come out in the first cycle after reset is released
    a_idle_after_reset: assert property (
        @(posedge clock)
        $rose(reset) |-> !out_valid
    ) else $error("out_valid high right after reset release");

    // A stalled sink blocks the input, so the next cycle carries no beat
    a_no_beat_after_stall: assert property (
        @(posedge clock) disable iff (!reset)
        !out_ready |=> !out_valid
    ) else $error("out_valid high after an edge with out_ready low");

endmodule

// File: rtl/saturating_adder.sv
// Saturating adder that adds two signed values and clamps the sum between two limits
`timescale 1ns/1ps

module saturating_adder #(
    parameter int DATA_WIDTH = 16
) (
    input logic signed [DATA_WIDTH-1:0] a,
    input logic signed [DATA_WIDTH-1:0] b,
    input logic signed [DATA_WIDTH-1:0] limit_pos,
    input logic signed [DATA_WIDTH-1:0] limit_neg,
    output logic signed [DATA_WIDTH-1:0] sum
);

    // One extra bit holds any sum of two operands without wrapping
    logic signed [DATA_WIDTH:0] a_wide;
    logic signed [DATA_WIDTH:0] b_wide;
    logic signed [DATA_WIDTH:0] sum_wide;

    // The limits are widened the same way so the compares stay signed
    logic signed [DATA_WIDTH:0] limit_pos_wide;
    logic signed [DATA_WIDTH:0] limit_neg_wide;

    // Signed operands sign-extend into the wider vectors
    assign a_wide = a;
    assign b_wide = b;
    assign limit_pos_wide = limit_pos;
    assign limit_neg_wide = limit_neg;

    assign sum_wide = a_wide + b_wide;

    always_comb begin
        // Clamp at the top first, then at the bottom
        if (sum_wide > limit_pos_wide) begin
            sum = limit_pos;
        end else if (sum_wide < limit_neg_wide) begin
            sum = limit_neg;
        end else begin
            // Inside the limits the top bit is only a sign copy
            sum = sum_wide[DATA_WIDTH-1:0];
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the calibration testbench with Verilator, run it and scan the log for a failure
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -j 0 -f filelist.f --top-module calib_tb \
    -Mdir obj_dir -o calib_sim > build.log 2>&1 \
    && ./obj_dir/calib_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
